// ==== verilog.f ====
+incdir+logic
logic/peri_pkg.sv
logic/axi4l_wb_bridge.sv
logic/wb_page_decoder.sv
logic/sys_ctrl_regs.sv
logic/frame_monitor.sv
logic/peri_ctrl_top.sv
testbench/peri_ctrl_asserts.sv
testbench/peri_ctrl_checker.sv
testbench/peri_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: peri_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/peri_pkg.sv
      - logic/axi4l_wb_bridge.sv
      - logic/wb_page_decoder.sv
      - logic/sys_ctrl_regs.sv
      - logic/frame_monitor.sv
      - logic/peri_ctrl_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/peri_ctrl_asserts.sv
      - testbench/peri_ctrl_checker.sv
      - testbench/peri_ctrl_tb.sv

// ==== testbench/peri_ctrl_tb.sv ====
// ----------------------------------------------------------
// peripheral control testbench
// AXI4-Lite and camera stream stimulus with a register map model
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "peri_config.svh"

module peri_ctrl_tb;

    import peri_pkg::*;

    localparam int N_ACCESS    = 57;
    localparam int N_BEATS     = 450;
    localparam int CYCLE_LIMIT = 20 * N_ACCESS + N_BEATS + 200;

    localparam logic [31:0] SYS_BASE   = {`PAGE_SYS, 12'h000};
    localparam logic [31:0] FMON_BASE  = {`PAGE_FMON, 12'h000};
    localparam logic [31:0] SWR_ADDR   = SYS_BASE + 4 * `REG_SYS_SW_RESET;
    localparam logic [31:0] CAM_ADDR   = SYS_BASE + 4 * `REG_SYS_CAM_ENABLE;
    localparam logic [31:0] CSI_ADDR   = SYS_BASE + 4 * `REG_SYS_CSI_TYPE;
    localparam logic [31:0] FRAME_ADDR = FMON_BASE + 4 * `REG_FMON_FRAME_CNT;
    localparam logic [31:0] LINE_ADDR  = FMON_BASE + 4 * `REG_FMON_LINE_CNT;

    logic        axi4_mem_aclk = 1'b0;
    logic        wb_peri_rst_i;
    axil_req_t   axil_req_i;
    axil_rsp_t   axil_rsp_o;
    logic [3:0]  dip_sw_i;
    video_beat_t cam_beat_i;
    logic        cam_valid_i;
    logic        cam_gpio_o;
    logic [1:0]  led_o;
    logic [31:0] exp_rdata;
    logic        pin_check;
    logic        exp_gpio;
    logic        exp_toggle;
    int          err_cnt;
    int          cycles = 0;
    logic [31:0] lfsr   = 32'hd52d_b343;

    // register map model
    logic        m_sw_reset;
    logic        m_cam_enable;
    logic [7:0]  m_csi_type;
    int          m_frames;
    int          m_lines;

    always #5 axi4_mem_aclk = ~axi4_mem_aclk;

    peri_ctrl_top dut_i (.*);

    peri_ctrl_checker u_checker (
        .axi4_mem_aclk (axi4_mem_aclk),
        .wb_peri_rst_i (wb_peri_rst_i),
        .axil_req_i    (axil_req_i),
        .axil_rsp_i    (axil_rsp_o),
        .cam_gpio_i    (cam_gpio_o),
        .led_i         (led_o),
        .exp_rdata_i   (exp_rdata),
        .pin_check_i   (pin_check),
        .exp_gpio_i    (exp_gpio),
        .exp_toggle_i  (exp_toggle),
        .err_cnt_o     (err_cnt)
    );

    // fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] v;
        v = '0;
        if (addr[31:12] == `PAGE_SYS) begin
            case (addr[11:2])
                `REG_SYS_ID:         v = `SYS_ID_VALUE;
                `REG_SYS_SW_RESET:   v = {31'd0, m_sw_reset};
                `REG_SYS_CAM_ENABLE: v = {31'd0, m_cam_enable};
                `REG_SYS_CSI_TYPE:   v = {24'd0, m_csi_type};
                default:             v = '0;
            endcase
        end else if (addr[31:12] == `PAGE_FMON) begin
            case (addr[11:2])
                `REG_FMON_FRAME_CNT: v = m_frames;
                `REG_FMON_LINE_CNT:  v = m_lines;
                default:             v = '0;
            endcase
        end
        return v;
    endfunction

    function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data);
        if (addr[31:12] == `PAGE_SYS) begin
            case (addr[11:2])
                `REG_SYS_SW_RESET:   m_sw_reset   = data[0];
                `REG_SYS_CAM_ENABLE: m_cam_enable = data[0];
                `REG_SYS_CSI_TYPE:   m_csi_type   = data[7:0];
                default: ;
            endcase
        end
        if ((addr[31:12] == `PAGE_FMON && addr[11:2] == `REG_FMON_FRAME_CNT) || m_sw_reset) begin
            m_frames = 0;
            m_lines  = 0;
        end
    endfunction

    // ------------------------------------------------------------
    // bus and stream drivers, all end just after a falling edge
    // ------------------------------------------------------------
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        int hold;
        hold = rand_bits(2);    // cycles of bready low
        @(negedge axi4_mem_aclk);
        axil_req_i.awaddr  = addr;
        axil_req_i.wdata   = data;
        axil_req_i.awvalid = 1'b1;
        axil_req_i.wvalid  = 1'b1;
        axil_req_i.bready  = (hold == 0);
        @(posedge axi4_mem_aclk);
        while (!axil_rsp_o.awready) @(posedge axi4_mem_aclk);
        ref_write(addr, data);
        @(negedge axi4_mem_aclk);
        axil_req_i.awvalid = 1'b0;
        axil_req_i.wvalid  = 1'b0;
        repeat (hold) @(negedge axi4_mem_aclk);
        axil_req_i.bready = 1'b1;
        @(posedge axi4_mem_aclk);
        while (!axil_rsp_o.bvalid) @(posedge axi4_mem_aclk);
        @(negedge axi4_mem_aclk);
        axil_req_i.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr);
        int hold;
        hold = rand_bits(2);
        @(negedge axi4_mem_aclk);
        exp_rdata          = ref_read(addr);
        axil_req_i.araddr  = addr;
        axil_req_i.arvalid = 1'b1;
        axil_req_i.rready  = (hold == 0);
        @(posedge axi4_mem_aclk);
        while (!axil_rsp_o.arready) @(posedge axi4_mem_aclk);
        @(negedge axi4_mem_aclk);
        axil_req_i.arvalid = 1'b0;
        repeat (hold) @(negedge axi4_mem_aclk);
        axil_req_i.rready = 1'b1;
        @(posedge axi4_mem_aclk);
        while (!axil_rsp_o.rvalid) @(posedge axi4_mem_aclk);
        @(negedge axi4_mem_aclk);
        axil_req_i.rready = 1'b0;
    endtask

    task automatic read_counters();
        axi_read(FRAME_ADDR);
        axi_read(LINE_ADDR);
    endtask

    task automatic drive_stream(input int n);
        repeat (n) begin
            @(negedge axi4_mem_aclk);
            cam_valid_i     = (rand_bits(2) != 0);
            cam_beat_i.user = (rand_bits(4) == 0);
            cam_beat_i.last = (rand_bits(2) == 0);
            cam_beat_i.data = `PIX_W'(rand_bits(`PIX_W));
            if (cam_valid_i && !m_sw_reset) begin
                m_frames += cam_beat_i.user;
                m_lines  += cam_beat_i.last;
            end
        end
        @(negedge axi4_mem_aclk);
        cam_valid_i = 1'b0;
    endtask

    task automatic check_pins();
        @(negedge axi4_mem_aclk);
        exp_gpio   = m_cam_enable & dip_sw_i[0];
        exp_toggle = m_frames[0];
        pin_check  = 1'b1;
        @(negedge axi4_mem_aclk);
        pin_check  = 1'b0;
    endtask

    always @(posedge axi4_mem_aclk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        int i;
        int assert_errs;
        axil_req_i    = '0;
        dip_sw_i      = 4'h0;
        cam_beat_i    = '0;
        cam_valid_i   = 1'b0;
        exp_rdata     = '0;
        pin_check     = 1'b0;
        exp_gpio      = 1'b0;
        exp_toggle    = 1'b0;
        m_sw_reset    = 1'b0;
        m_cam_enable  = 1'b0;
        m_csi_type    = `CSI_TYPE_RESET;
        m_frames      = 0;
        m_lines       = 0;
        wb_peri_rst_i = 1'b1;
        repeat (10) @(posedge axi4_mem_aclk);
        @(negedge axi4_mem_aclk);
        wb_peri_rst_i = 1'b0;

        for (i = 0; i < 4; i++) begin
            axi_read(SYS_BASE + 4 * i);     // ID and reset values
        end
        check_pins();

        for (i = 0; i < 8; i++) begin
            axi_write(CSI_ADDR, rand_bits(32));
            axi_read(CSI_ADDR);
            axi_write(CAM_ADDR, rand_bits(32));
            axi_read(CAM_ADDR);
        end

        // gpio gating over enable x switch
        for (i = 0; i < 4; i++) begin
            axi_write(CAM_ADDR, {31'd0, i[1]});
            dip_sw_i    = 4'(rand_bits(4));
            dip_sw_i[0] = i[0];
            check_pins();
        end

        drive_stream(200);
        read_counters();
        check_pins();

        axi_write(FRAME_ADDR, rand_bits(32));
        read_counters();
        drive_stream(100);
        read_counters();
        axi_write(SWR_ADDR, 32'd1);
        drive_stream(50);
        read_counters();
        check_pins();
        axi_write(SWR_ADDR, 32'd0);
        drive_stream(100);
        read_counters();
        check_pins();

        // unmapped page and offsets
        axi_write(32'h5000_0000, rand_bits(32));
        axi_read(32'h5000_0000);
        axi_read(SYS_BASE + 32'h10);
        axi_read(FMON_BASE + 32'h8);

        repeat (2) @(negedge axi4_mem_aclk);
        assert_errs = dut_i.u_bridge.u_asserts.fail_cnt;
        $display("checker errors %0d, assertion failures %0d", err_cnt, assert_errs);
        if (err_cnt == 0 && assert_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/peri_ctrl_checker.sv ====
// ----------------------------------------------------------
// checker for response timing, read data and pins
// ----------------------------------------------------------
`timescale 1ns/1ns

module peri_ctrl_checker (
    input  logic                axi4_mem_aclk,
    input  logic                wb_peri_rst_i,
    input  peri_pkg::axil_req_t axil_req_i,
    input  peri_pkg::axil_rsp_t axil_rsp_i,
    input  logic                cam_gpio_i,
    input  logic [1:0]          led_i,
    input  logic [31:0]         exp_rdata_i,
    input  logic                pin_check_i,
    input  logic                exp_gpio_i,
    input  logic                exp_toggle_i,
    output int                  err_cnt_o
);

    logic wr_hs_q;
    logic rd_hs_q;
    logic bvalid_q;
    logic rvalid_q;

    initial err_cnt_o = 0;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %0t ns %s = %h, expected %h", $time, name, got, exp);
            err_cnt_o++;
        end
    endtask

    always @(posedge axi4_mem_aclk) begin
        if (wb_peri_rst_i) begin
            wr_hs_q  <= 1'b0;
            rd_hs_q  <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            // responses rise exactly one cycle after their handshake
            compare("bvalid rise", axil_rsp_i.bvalid & ~bvalid_q, wr_hs_q);
            compare("rvalid rise", axil_rsp_i.rvalid & ~rvalid_q, rd_hs_q);
            if (axil_rsp_i.bvalid && axil_req_i.bready) begin
                compare("bresp", axil_rsp_i.bresp, 2'b00);
            end
            if (axil_rsp_i.rvalid && axil_req_i.rready) begin
                compare("rdata", axil_rsp_i.rdata, exp_rdata_i);
                compare("rresp", axil_rsp_i.rresp, 2'b00);
            end
            if (pin_check_i) begin
                compare("cam_gpio_o", cam_gpio_i, exp_gpio_i);
                compare("led_o[1]", led_i[1], exp_gpio_i);
                compare("led_o[0]", led_i[0], exp_toggle_i);   // frame parity
            end
            // write handshake needs both AW and W
            wr_hs_q  <= axil_req_i.awvalid & axil_rsp_i.awready
                      & axil_req_i.wvalid & axil_rsp_i.wready;
            rd_hs_q  <= axil_req_i.arvalid & axil_rsp_i.arready;
            bvalid_q <= axil_rsp_i.bvalid;
            rvalid_q <= axil_rsp_i.rvalid;
        end
    end

endmodule

// ==== testbench/peri_ctrl_asserts.sv ====
// ----------------------------------------------------------
// AXI4-Lite handshake assertions on the bridge
// ----------------------------------------------------------
`timescale 1ns/1ns

module peri_ctrl_asserts (
    input logic                axi4_mem_aclk,
    input logic                wb_peri_rst_i,
    input peri_pkg::axil_req_t axil_req_i,
    input peri_pkg::axil_rsp_t axil_rsp_i
);

    int fail_cnt = 0;

    bvalid_held: assert property (@(posedge axi4_mem_aclk) disable iff (wb_peri_rst_i)
        axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
    else begin
        $error("bvalid dropped before its handshake");
        fail_cnt++;
    end

    rvalid_held: assert property (@(posedge axi4_mem_aclk) disable iff (wb_peri_rst_i)
        axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid)
    else begin
        $error("rvalid dropped before its handshake");
        fail_cnt++;
    end

    // nothing accepted while a response waits
    no_ready_pending: assert property (@(posedge axi4_mem_aclk) disable iff (wb_peri_rst_i)
        axil_rsp_i.bvalid || axil_rsp_i.rvalid
        |-> !(axil_rsp_i.awready || axil_rsp_i.wready || axil_rsp_i.arready))
    else begin
        $error("ready raised while a response was pending");
        fail_cnt++;
    end

endmodule

bind axi4l_wb_bridge peri_ctrl_asserts u_asserts (
    .axi4_mem_aclk (axi4_mem_aclk),
    .wb_peri_rst_i (wb_peri_rst_i),
    .axil_req_i    (axil_req_i),
    .axil_rsp_i    (axil_rsp_o)
);

// ==== logic/peri_ctrl_top.sv ====
// ----------------------------------------------------------
// peripheral control top level
// ----------------------------------------------------------
`timescale 1ns/1ns

module peri_ctrl_top (
    input  logic                  axi4_mem_aclk,
    input  logic                  wb_peri_rst_i,
    input  peri_pkg::axil_req_t   axil_req_i,
    output peri_pkg::axil_rsp_t   axil_rsp_o,
    input  logic [3:0]            dip_sw_i,
    input  peri_pkg::video_beat_t cam_beat_i,
    input  logic                  cam_valid_i,
    output logic                  cam_gpio_o,
    output logic [1:0]            led_o
);

    import peri_pkg::*;

    wb_req_t wb_req;
    logic    wb_stb;
    wb_rsp_t wb_rsp;
    logic    sys_stb;
    wb_rsp_t sys_rsp;
    logic    fmon_stb;
    wb_rsp_t fmon_rsp;
    logic    sw_reset;
    logic    frame_toggle;

    // ------------------------------------------------------------
    // bus
    // ------------------------------------------------------------
    axi4l_wb_bridge u_bridge (
        .axi4_mem_aclk (axi4_mem_aclk),
        .wb_peri_rst_i (wb_peri_rst_i),
        .axil_req_i    (axil_req_i),
        .axil_rsp_o    (axil_rsp_o),
        .wb_req_o      (wb_req),
        .wb_stb_o      (wb_stb),
        .wb_rsp_i      (wb_rsp)
    );

    wb_page_decoder u_decoder (
        .wb_req_i   (wb_req),
        .wb_stb_i   (wb_stb),
        .wb_rsp_o   (wb_rsp),
        .sys_stb_o  (sys_stb),
        .sys_rsp_i  (sys_rsp),
        .fmon_stb_o (fmon_stb),
        .fmon_rsp_i (fmon_rsp)
    );

    // ------------------------------------------------------------
    // slaves
    // ------------------------------------------------------------
    sys_ctrl_regs u_sys_ctrl (
        .axi4_mem_aclk (axi4_mem_aclk),
        .wb_peri_rst_i (wb_peri_rst_i),
        .wb_req_i      (wb_req),
        .wb_stb_i      (sys_stb),
        .wb_rsp_o      (sys_rsp),
        .dip_sw_i      (dip_sw_i),
        .sw_reset_o    (sw_reset),
        .cam_gpio_o    (cam_gpio_o)
    );

    frame_monitor u_frame_mon (
        .axi4_mem_aclk  (axi4_mem_aclk),
        .wb_peri_rst_i  (wb_peri_rst_i),
        .sw_reset_i     (sw_reset),
        .beat_i         (cam_beat_i),
        .beat_valid_i   (cam_valid_i),
        .wb_req_i       (wb_req),
        .wb_stb_i       (fmon_stb),
        .wb_rsp_o       (fmon_rsp),
        .frame_toggle_o (frame_toggle)
    );

    assign led_o = {cam_gpio_o, frame_toggle};

endmodule

// ==== logic/frame_monitor.sv ====
// ----------------------------------------------------------
// camera stream frame monitor
// frame and line counters, frame toggle
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "peri_config.svh"

module frame_monitor (
    input  logic                  axi4_mem_aclk,
    input  logic                  wb_peri_rst_i,
    input  logic                  sw_reset_i,
    input  peri_pkg::video_beat_t beat_i,
    input  logic                  beat_valid_i,
    input  peri_pkg::wb_req_t     wb_req_i,
    input  logic                  wb_stb_i,
    output peri_pkg::wb_rsp_t     wb_rsp_o,
    output logic                  frame_toggle_o
);

    logic [`WB_OFS_W-1:0]    ofs;
    logic                    cnt_clear;
    logic [`PERI_DATA_W-1:0] frame_cnt_q;
    logic [`PERI_DATA_W-1:0] line_cnt_q;
    logic                    toggle_q;

    assign ofs = wb_req_i.adr[`WB_OFS_W-1:0];

    // software reset holds everything clear while set
    assign cnt_clear = sw_reset_i
                     | (wb_stb_i & wb_req_i.we & (ofs == `REG_FMON_FRAME_CNT));

    // ------------------------------------------------------------
    // counters
    // ------------------------------------------------------------
    always_ff @(posedge axi4_mem_aclk) begin
        if (wb_peri_rst_i || cnt_clear) begin
            frame_cnt_q <= '0;
            line_cnt_q  <= '0;
            toggle_q    <= 1'b0;    // keeps parity with the frame count
        end else if (beat_valid_i) begin
            if (beat_i.user) begin
                frame_cnt_q <= frame_cnt_q + 1'b1;
                toggle_q    <= ~toggle_q;
            end
            if (beat_i.last) begin
                line_cnt_q <= line_cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (ofs)
            `REG_FMON_FRAME_CNT: wb_rsp_o.dat = frame_cnt_q;
            `REG_FMON_LINE_CNT:  wb_rsp_o.dat = line_cnt_q;
            default:             wb_rsp_o.dat = '0;
        endcase
        wb_rsp_o.ack = wb_stb_i;
    end

    assign frame_toggle_o = toggle_q;

endmodule

// ==== logic/sys_ctrl_regs.sv ====
// ----------------------------------------------------------
// system control registers
// ID, software reset, camera enable and CSI data type
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "peri_config.svh"

module sys_ctrl_regs (
    input  logic              axi4_mem_aclk,
    input  logic              wb_peri_rst_i,
    input  peri_pkg::wb_req_t wb_req_i,
    input  logic              wb_stb_i,
    output peri_pkg::wb_rsp_t wb_rsp_o,
    input  logic [3:0]        dip_sw_i,
    output logic              sw_reset_o,
    output logic              cam_gpio_o
);

    logic [`WB_OFS_W-1:0] ofs;
    logic                 wr_en;
    logic                 sw_reset_q;
    logic                 cam_enable_q;
    logic [7:0]           csi_type_q;

    assign ofs   = wb_req_i.adr[`WB_OFS_W-1:0];
    assign wr_en = wb_stb_i & wb_req_i.we;

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------
    always_ff @(posedge axi4_mem_aclk) begin
        if (wb_peri_rst_i) begin
            sw_reset_q   <= 1'b0;
            cam_enable_q <= 1'b0;
            csi_type_q   <= `CSI_TYPE_RESET;
        end else if (wr_en) begin
            case (ofs)
                `REG_SYS_SW_RESET:   sw_reset_q   <= wb_req_i.dat[0];
                `REG_SYS_CAM_ENABLE: cam_enable_q <= wb_req_i.dat[0];
                `REG_SYS_CSI_TYPE:   csi_type_q   <= wb_req_i.dat[7:0];
                default: ;      // ID and unmapped offsets ignore writes
            endcase
        end
    end

    // read back
    always_comb begin
        case (ofs)
            `REG_SYS_ID:         wb_rsp_o.dat = `SYS_ID_VALUE;
            `REG_SYS_SW_RESET:   wb_rsp_o.dat = {{(`PERI_DATA_W-1){1'b0}}, sw_reset_q};
            `REG_SYS_CAM_ENABLE: wb_rsp_o.dat = {{(`PERI_DATA_W-1){1'b0}}, cam_enable_q};
            `REG_SYS_CSI_TYPE:   wb_rsp_o.dat = {{(`PERI_DATA_W-8){1'b0}}, csi_type_q};
            default:             wb_rsp_o.dat = '0;
        endcase
        wb_rsp_o.ack = wb_stb_i;
    end

    assign sw_reset_o = sw_reset_q;
    assign cam_gpio_o = cam_enable_q & dip_sw_i[0];     // switch 0 gates the sensor

endmodule

// ==== logic/wb_page_decoder.sv ====
// ----------------------------------------------------------
// register bus page decoder
// strobe per slave, merged response, default ack
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "peri_config.svh"

module wb_page_decoder (
    input  peri_pkg::wb_req_t wb_req_i,
    input  logic              wb_stb_i,
    output peri_pkg::wb_rsp_t wb_rsp_o,
    output logic              sys_stb_o,
    input  peri_pkg::wb_rsp_t sys_rsp_i,
    output logic              fmon_stb_o,
    input  peri_pkg::wb_rsp_t fmon_rsp_i
);

    logic [`WB_PAGE_W-1:0] page;
    logic                  sys_hit;
    logic                  fmon_hit;

    assign page     = wb_req_i.adr[`WB_ADR_W-1 -: `WB_PAGE_W];
    assign sys_hit  = (page == `PAGE_SYS);
    assign fmon_hit = (page == `PAGE_FMON);

    assign sys_stb_o  = wb_stb_i & sys_hit;
    assign fmon_stb_o = wb_stb_i & fmon_hit;

    // ------------------------------------------------------------
    // response merge
    // ------------------------------------------------------------
    always_comb begin
        if (sys_stb_o) begin
            wb_rsp_o = sys_rsp_i;
        end else if (fmon_stb_o) begin
            wb_rsp_o = fmon_rsp_i;
        end else begin
            // unmapped page reads zero, ack follows strobe
            wb_rsp_o.dat = '0;
            wb_rsp_o.ack = wb_stb_i;
        end
    end

endmodule

// ==== logic/axi4l_wb_bridge.sv ====
// ----------------------------------------------------------
// AXI4-Lite slave to single-cycle register bus
// one bus cycle per accepted access, write before read
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "peri_config.svh"

module axi4l_wb_bridge (
    input  logic                axi4_mem_aclk,
    input  logic                wb_peri_rst_i,
    input  peri_pkg::axil_req_t axil_req_i,
    output peri_pkg::axil_rsp_t axil_rsp_o,
    output peri_pkg::wb_req_t   wb_req_o,
    output logic                wb_stb_o,
    input  peri_pkg::wb_rsp_t   wb_rsp_i
);

    logic                    wr_accept;
    logic                    rd_accept;
    logic                    resp_busy;
    logic                    bvalid_q;
    logic                    rvalid_q;
    logic [`PERI_DATA_W-1:0] rdata_q;

    // ------------------------------------------------------------
    // arbitration
    // ------------------------------------------------------------
    assign resp_busy = bvalid_q | rvalid_q;     // nothing new while a response waits

    // AW and W taken together
    assign wr_accept = axil_req_i.awvalid & axil_req_i.wvalid & ~resp_busy;
    assign rd_accept = axil_req_i.arvalid & ~wr_accept & ~resp_busy;

    // ------------------------------------------------------------
    // register bus cycle
    // ------------------------------------------------------------
    always_comb begin
        if (wr_accept) begin
            wb_req_o.adr = axil_req_i.awaddr[`PERI_ADDR_W-1 -: `WB_ADR_W];
        end else begin
            wb_req_o.adr = axil_req_i.araddr[`PERI_ADDR_W-1 -: `WB_ADR_W];
        end
        wb_req_o.dat = axil_req_i.wdata;
        wb_req_o.we  = wr_accept;
    end

    assign wb_stb_o = wr_accept | rd_accept;

    // ------------------------------------------------------------
    // response channels
    // ------------------------------------------------------------
    always_ff @(posedge axi4_mem_aclk) begin
        if (wb_peri_rst_i) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid_q <= 1'b1;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end

            if (rd_accept) begin
                rvalid_q <= 1'b1;
            end else if (axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // slaves ack inside the strobe cycle
    always_ff @(posedge axi4_mem_aclk) begin
        if (rd_accept && wb_rsp_i.ack) begin
            rdata_q <= wb_rsp_i.dat;
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_accept;
        axil_rsp_o.wready  = wr_accept;
        axil_rsp_o.bresp   = `AXI_RESP_OKAY;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.arready = rd_accept;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = `AXI_RESP_OKAY;
        axil_rsp_o.rvalid  = rvalid_q;
    end

endmodule

// ==== logic/peri_pkg.sv ====
// ----------------------------------------------------------
// peripheral control types
// AXI4-Lite channels, register bus and camera beat
// ----------------------------------------------------------
`include "peri_config.svh"

package peri_pkg;

    // ------------------------------------------------------------
    // AXI4-Lite, master to slave and back
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`PERI_ADDR_W-1:0] awaddr;
        logic                    awvalid;
        logic [`PERI_DATA_W-1:0] wdata;
        logic                    wvalid;
        logic                    bready;
        logic [`PERI_ADDR_W-1:0] araddr;
        logic                    arvalid;
        logic                    rready;
    } axil_req_t;

    typedef struct packed {
        logic                    awready;
        logic                    wready;
        logic [1:0]              bresp;
        logic                    bvalid;
        logic                    arready;
        logic [`PERI_DATA_W-1:0] rdata;
        logic [1:0]              rresp;
        logic                    rvalid;
    } axil_rsp_t;

    // ------------------------------------------------------------
    // register bus, strobe kept outside
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`WB_ADR_W-1:0]    adr;   // word address
        logic [`PERI_DATA_W-1:0] dat;
        logic                    we;
    } wb_req_t;

    typedef struct packed {
        logic [`PERI_DATA_W-1:0] dat;
        logic                    ack;
    } wb_rsp_t;

    // camera pixel beat
    typedef struct packed {
        logic              user;    // frame start
        logic              last;    // line end
        logic [`PIX_W-1:0] data;
    } video_beat_t;

endpackage

// ==== logic/peri_config.svh ====
// ----------------------------------------------------------
// peripheral control configuration
// bus widths, page map, register offsets and reset values
// ----------------------------------------------------------
`ifndef PERI_CONFIG_SVH
`define PERI_CONFIG_SVH

// bus widths
`define PERI_ADDR_W         32
`define PERI_DATA_W         32
`define WB_ADR_W            30
`define WB_PAGE_W           20      // word address [29:10], 4 KB pages
`define WB_OFS_W            10
`define AXI_RESP_OKAY       2'b00

// pages of the word address
`define PAGE_SYS            20'h40000   // 0x4000_0000-0x4000_0fff
`define PAGE_FMON           20'h40010   // 0x4001_0000-0x4001_0fff

`define SYS_ID_VALUE        32'h0123_4567
`define CSI_TYPE_RESET      8'h2b
`define PIX_W               10

// system control offsets
`define REG_SYS_ID          0
`define REG_SYS_SW_RESET    1
`define REG_SYS_CAM_ENABLE  2
`define REG_SYS_CSI_TYPE    3

// frame monitor offsets
`define REG_FMON_FRAME_CNT  0
`define REG_FMON_LINE_CNT   1

`endif
